// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_adam_io
FILELIST  = adam_io.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== adam_io.f ====
+incdir+.
adam_io_pkg.sv
ctrl_port_if.sv
clock_enable_gen.sv
controller_port.sv
controller_bank.sv
sync_conditioner.sv
adam_io_top.sv
tb_adam_io.sv

// ==== adam_io_config.svh ====
//====================
// Widths, divider size and keypad codes
// for the controller front end and video glue
//====================

`ifndef ADAM_IO_CONFIG_SVH
`define ADAM_IO_CONFIG_SVH

// Host joystick word and derived controller words
`define ADAM_JOY_W      32
`define ADAM_KEYPAD_W   20
`define ADAM_NIBBLE_W   4
`define ADAM_NUM_PORTS  2

// Keypad keys in the keypad word, the rest being four directions and two fire buttons
`define ADAM_NUM_KEYS   (`ADAM_KEYPAD_W - `ADAM_NIBBLE_W - 2)

// Pixel clock-enable divider
`define ADAM_DIV_W      3

//====================
// Keypad codes as the console reads them
//====================
`define ADAM_KEY_0      4'b0011
`define ADAM_KEY_1      4'b1110
`define ADAM_KEY_2      4'b1101
`define ADAM_KEY_3      4'b0110
`define ADAM_KEY_4      4'b0001
`define ADAM_KEY_5      4'b1001
`define ADAM_KEY_6      4'b0111
`define ADAM_KEY_7      4'b1100
`define ADAM_KEY_8      4'b1000
`define ADAM_KEY_9      4'b1011
`define ADAM_KEY_STAR   4'b1010
`define ADAM_KEY_HASH   4'b0101
// Purple and blue side triggers
`define ADAM_KEY_PT     4'b0100
`define ADAM_KEY_BT     4'b0010
`define ADAM_KEY_NONE   4'b1111

`endif

// ==== adam_io_pkg.sv ====
//====================
// Controller types: direction lines, keypad word
// and the port nibble union
//====================

`default_nettype none

`include "adam_io_config.svh"

package adam_io_pkg;

        // Four direction lines, polarity depends on where it is used
        typedef struct packed {
                logic up;
                logic down;
                logic left;
                logic right;
        } dir_t;

        //====================
        // One player's controls, in encoder priority order
        //====================
        // keys[0..9] are digits, then star, hash, purple and blue trigger
        typedef struct packed {
                logic [`ADAM_NUM_KEYS-1:0] keys;
                dir_t                      dirs;
                logic                      fire1;
                logic                      fire2;
        } keypad_t;

        //====================
        // Nibble on one controller port
        //====================
        // Keypad segment reads it as a key code,
        // joystick segment as active-low direction lines
        typedef union packed {
                logic [`ADAM_NIBBLE_W-1:0] key_code;
                dir_t                      dirs;
        } port_nibble_u;

endpackage

`default_nettype wire

// ==== adam_io_top.sv ====
//====================
// Top level: clock enables, controller
// front end and sync conditioner
//====================

`timescale 1ns/1ps
`default_nettype none

`include "adam_io_config.svh"

module adam_io_top (
        input  wire                           CLK_VIDEO,
        input  wire                           arst_n_i,

        // Host joystick words and player swap
        input  wire  [`ADAM_JOY_W-1:0]        joy0_i,
        input  wire  [`ADAM_JOY_W-1:0]        joy1_i,
        input  wire                           swap_i,

        // Console controller ports
        input  wire  [`ADAM_NUM_PORTS-1:0]    ctrl_sel_key_n_i,
        input  wire  [`ADAM_NUM_PORTS-1:0]    ctrl_sel_joy_n_i,
        output adam_io_pkg::port_nibble_u     ctrl_nibble_o [`ADAM_NUM_PORTS],
        output logic [`ADAM_NUM_PORTS-1:0]    ctrl_fire_n_o,

        // Video syncs
        input  wire                           hsync_n_i,
        input  wire                           vsync_n_i,
        output logic                          hs_o,
        output logic                          vs_o,

        // Pixel clock enables
        output logic                          ce_10m7_o,
        output logic                          ce_5m3_o
);

        clock_enable_gen u_clock_enable_gen (
                .CLK_VIDEO (CLK_VIDEO),
                .arst_n_i  (arst_n_i),
                .ce_10m7_o (ce_10m7_o),
                .ce_5m3_o  (ce_5m3_o)
        );

        controller_bank u_controller_bank (
                .CLK_VIDEO   (CLK_VIDEO),
                .joy0_i      (joy0_i),
                .joy1_i      (joy1_i),
                .swap_i      (swap_i),
                .sel_key_n_i (ctrl_sel_key_n_i),
                .sel_joy_n_i (ctrl_sel_joy_n_i),
                .nibble_o    (ctrl_nibble_o),
                .fire_n_o    (ctrl_fire_n_o)
        );

        sync_conditioner u_sync_conditioner (
                .CLK_VIDEO (CLK_VIDEO),
                .arst_n_i  (arst_n_i),
                .hsync_n_i (hsync_n_i),
                .vsync_n_i (vsync_n_i),
                .hs_o      (hs_o),
                .vs_o      (vs_o)
        );

endmodule

`default_nettype wire

// ==== adam_io_vectors.txt ====
# joy0 joy1 swap sel_key_n sel_joy_n | expected nibble0 nibble1 fire_n, all hex
# Bit p of each select and of fire_n belongs to controller port p
# Keypad segment only, one key per port, then priority and fire2
00000000 00000000 0 0 3 f f 3
00000100 00000200 0 0 3 3 e 3
00000400 00000800 0 0 3 d 6 3
00001000 00002000 0 0 3 1 9 3
00004000 00008000 0 0 3 7 c 3
00010000 00020000 0 0 3 8 b 3
00000040 00000080 0 0 3 a 5 3
00040000 00080000 0 0 3 4 2 3
000fffc0 000f0080 0 0 3 3 8 3
00002020 00000010 0 0 3 9 f 2
00000000 000c0020 0 0 3 f 4 1
fff00000 abc00100 0 0 3 f 3 3
# Joystick segment only
00000000 00000000 0 3 0 f f 3
00000008 00000001 0 3 0 7 e 3
00000004 00000002 0 3 0 b d 3
0000001f 0000002a 0 3 0 0 5 2
000fff25 00000015 0 3 0 a a 1
# Both segments selected
00000108 00000201 0 0 0 3 e 3
00002032 00000010 0 0 0 9 f 0
00000045 0000400f 0 0 0 a 0 3
# Mixed selects per port, and no segment selected
00000818 00000423 0 2 1 6 c 3
000fffff ffffffff 0 3 3 f f 3
00000039 00080020 0 1 2 6 2 0
# Player swap
00000100 00000200 1 0 3 e 3 3
00000018 00000001 1 3 0 e 7 1
00040020 00000002 1 0 0 d 4 1

// ==== clock_enable_gen.sv ====
//====================
// Pixel-rate clock enables, about 10.7 MHz
// and 5.3 MHz, from a free-running divider
//====================

`timescale 1ns/1ps
`default_nettype none

`include "adam_io_config.svh"

module clock_enable_gen (
        input  wire  CLK_VIDEO,
        input  wire  arst_n_i,
        output logic ce_10m7_o,
        output logic ce_5m3_o
);

        logic [`ADAM_DIV_W-1:0] div_q;

        // Enables are registered from the previous divider value
        always_ff @(posedge CLK_VIDEO or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        div_q     <= '0;
                        ce_10m7_o <= 1'b0;
                        ce_5m3_o  <= 1'b0;
                end else begin
                        div_q     <= div_q + 1'b1;
                        ce_10m7_o <= (div_q[1:0] == 2'b00);
                        ce_5m3_o  <= (div_q == '0);
                end
        end

        //====================
        // Checks
        //====================
        // Slow enable sits on a fast enable pulse
        a_ce_nested: assert property (
                @(posedge CLK_VIDEO) disable iff (!arst_n_i)
                ce_5m3_o |-> ce_10m7_o
        ) else $error("ce_5m3_o high without ce_10m7_o");

endmodule

`default_nettype wire

// ==== controller_bank.sv ====
//====================
// Player swap, joystick bit reordering
// and the controller port instances
//====================

`timescale 1ns/1ps
`default_nettype none

`include "adam_io_config.svh"

module controller_bank (
        input  wire                           CLK_VIDEO,
        input  wire  [`ADAM_JOY_W-1:0]        joy0_i,
        input  wire  [`ADAM_JOY_W-1:0]        joy1_i,
        input  wire                           swap_i,
        input  wire  [`ADAM_NUM_PORTS-1:0]    sel_key_n_i,
        input  wire  [`ADAM_NUM_PORTS-1:0]    sel_joy_n_i,
        output adam_io_pkg::port_nibble_u     nibble_o [`ADAM_NUM_PORTS],
        output logic [`ADAM_NUM_PORTS-1:0]    fire_n_o
);

        // Host word to keypad word; bits above 19 carry no controller function
        function automatic adam_io_pkg::keypad_t to_keypad(
                input logic [`ADAM_JOY_W-1:0] joy
        );
                adam_io_pkg::keypad_t kp;

                // Digits 0 to 9
                kp.keys[9:0]  = joy[17:8];
                kp.keys[10]   = joy[6];
                kp.keys[11]   = joy[7];
                kp.keys[12]   = joy[18];
                kp.keys[13]   = joy[19];
                kp.dirs.up    = joy[3];
                kp.dirs.down  = joy[2];
                kp.dirs.left  = joy[1];
                kp.dirs.right = joy[0];
                kp.fire1      = joy[4];
                kp.fire2      = joy[5];
                return kp;
        endfunction

        logic [`ADAM_JOY_W-1:0] player [`ADAM_NUM_PORTS];

        // Player A feeds port 0 and player B port 1
        assign player[0] = swap_i ? joy1_i : joy0_i;
        assign player[1] = swap_i ? joy0_i : joy1_i;

        //====================
        // Ports
        //====================
        for (genvar p = 0; p < `ADAM_NUM_PORTS; p++) begin : g_port
                ctrl_port_if cp_if (
                        .clk (CLK_VIDEO)
                );

                assign cp_if.keypad    = to_keypad(player[p]);
                assign cp_if.sel_key_n = sel_key_n_i[p];
                assign cp_if.sel_joy_n = sel_joy_n_i[p];

                controller_port u_port (
                        .cp (cp_if)
                );

                assign nibble_o[p] = cp_if.nibble;
                assign fire_n_o[p] = cp_if.fire_n;

                // Fire line only ever comes from the button of a selected segment
                a_fire_source: assert property (
                        @(posedge CLK_VIDEO)
                        !fire_n_o[p] |-> ((!sel_key_n_i[p] && player[p][5]) ||
                                          (!sel_joy_n_i[p] && player[p][4]))
                ) else $error("fire line low without a selected button");
        end

endmodule

`default_nettype wire

// ==== controller_port.sv ====
//====================
// One controller port: keypad priority encoder,
// joystick direction lines and fire select
//====================

`timescale 1ns/1ps
`default_nettype none

`include "adam_io_config.svh"

module controller_port (
        ctrl_port_if.port cp
);

        // Code per key, indexed like keypad_t.keys
        localparam logic [`ADAM_NIBBLE_W-1:0] KEY_CODES [`ADAM_NUM_KEYS] = '{
                `ADAM_KEY_0, `ADAM_KEY_1, `ADAM_KEY_2, `ADAM_KEY_3, `ADAM_KEY_4,
                `ADAM_KEY_5, `ADAM_KEY_6, `ADAM_KEY_7, `ADAM_KEY_8, `ADAM_KEY_9,
                `ADAM_KEY_STAR, `ADAM_KEY_HASH, `ADAM_KEY_PT, `ADAM_KEY_BT
        };

        adam_io_pkg::port_nibble_u key_seg;
        adam_io_pkg::port_nibble_u joy_seg;
        logic                      key_fire_n;
        logic                      joy_fire_n;

        //====================
        // Keypad segment
        //====================
        // Scan from the top so the lowest pressed key wins
        always_comb begin
                key_seg.key_code = '1;
                key_fire_n       = 1'b1;
                if (!cp.sel_key_n) begin
                        key_seg.key_code = `ADAM_KEY_NONE;
                        for (int i = `ADAM_NUM_KEYS - 1; i >= 0; i--) begin
                                if (cp.keypad.keys[i]) begin
                                        key_seg.key_code = KEY_CODES[i];
                                end
                        end
                        // Second button shares the line with the keypad
                        key_fire_n = ~cp.keypad.fire2;
                end
        end

        //====================
        // Joystick segment
        //====================
        always_comb begin
                joy_seg.key_code = '1;
                joy_fire_n       = 1'b1;
                if (!cp.sel_joy_n) begin
                        joy_seg.dirs.up    = ~cp.keypad.dirs.up;
                        joy_seg.dirs.down  = ~cp.keypad.dirs.down;
                        joy_seg.dirs.left  = ~cp.keypad.dirs.left;
                        joy_seg.dirs.right = ~cp.keypad.dirs.right;
                        joy_fire_n         = ~cp.keypad.fire1;
                end
        end

        // Both segments pull the shared lines low, so they AND together
        assign cp.nibble = key_seg.key_code & joy_seg.key_code;
        assign cp.fire_n = key_fire_n & joy_fire_n;

        // Idle port floats high on every line
        a_idle_high: assert property (
                @(posedge cp.clk)
                (cp.sel_key_n && cp.sel_joy_n) |->
                        (cp.nibble.key_code == 4'b1111 && cp.fire_n)
        ) else $error("controller port lines not idle with no segment selected");

endmodule

`default_nettype wire

// ==== ctrl_port_if.sv ====
//====================
// One controller port: keypad word and
// segment selects in, nibble and fire out
//====================

`timescale 1ns/1ps
`default_nettype none

interface ctrl_port_if (
        input wire clk
);

        adam_io_pkg::keypad_t      keypad;
        logic                      sel_key_n;
        logic                      sel_joy_n;
        adam_io_pkg::port_nibble_u nibble;
        logic                      fire_n;

        // Side that supplies the player controls and selects
        modport bank (
                input  clk,
                output keypad,
                output sel_key_n,
                output sel_joy_n,
                input  nibble,
                input  fire_n
        );

        // Side that decodes them into port lines
        modport port (
                input  clk,
                input  keypad,
                input  sel_key_n,
                input  sel_joy_n,
                output nibble,
                output fire_n
        );

endinterface

`default_nettype wire

// ==== sync_conditioner.sv ====
//====================
// Sync conditioning: active-low syncs to
// positive pulses, vsync aligned to hsync
//====================

`timescale 1ns/1ps
`default_nettype none

module sync_conditioner (
        input  wire  CLK_VIDEO,
        input  wire  arst_n_i,
        input  wire  hsync_n_i,
        input  wire  vsync_n_i,
        output logic hs_o,
        output logic vs_o
);

        logic hs_edge;

        // Hsync goes active while the registered copy is still low
        assign hs_edge = ~hs_o & ~hsync_n_i;

        always_ff @(posedge CLK_VIDEO or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        hs_o <= 1'b0;
                        vs_o <= 1'b0;
                end else begin
                        hs_o <= ~hsync_n_i;
                        // Vsync only moves at a line start
                        if (hs_edge) begin
                                vs_o <= ~vsync_n_i;
                        end
                end
        end

        //====================
        // Checks
        //====================
        a_vs_on_hs_edge: assert property (
                @(posedge CLK_VIDEO) disable iff (!arst_n_i)
                $changed(vs_o) |-> $past(hs_edge)
        ) else $error("vs_o changed away from an hsync leading edge");

endmodule

`default_nettype wire

// ==== tb_adam_io.sv ====
//====================
// Testbench for the controller front end and video glue
// Vector-driven port checks, clock enables, sync conditioning
//====================

`timescale 1ns/1ps
`default_nettype none

`include "adam_io_config.svh"

module tb_adam_io;

        localparam int RESET_CYCLES = 10;
        localparam int CE_CYCLES    = 32;
        localparam int SYNC_CYCLES  = 400;

        // One line of the vector file
        typedef struct packed {
                logic [`ADAM_JOY_W-1:0]     joy0;
                logic [`ADAM_JOY_W-1:0]     joy1;
                logic                       swap;
                logic [`ADAM_NUM_PORTS-1:0] sel_key_n;
                logic [`ADAM_NUM_PORTS-1:0] sel_joy_n;
                logic [`ADAM_NIBBLE_W-1:0]  exp_nibble0;
                logic [`ADAM_NIBBLE_W-1:0]  exp_nibble1;
                logic [`ADAM_NUM_PORTS-1:0] exp_fire_n;
        } vector_t;

        logic                       CLK_VIDEO;
        logic                       arst_n;
        logic [`ADAM_JOY_W-1:0]     joy0;
        logic [`ADAM_JOY_W-1:0]     joy1;
        logic                       swap;
        logic [`ADAM_NUM_PORTS-1:0] sel_key_n;
        logic [`ADAM_NUM_PORTS-1:0] sel_joy_n;
        logic                       hsync_n;
        logic                       vsync_n;
        adam_io_pkg::port_nibble_u  nibble [`ADAM_NUM_PORTS];
        logic [`ADAM_NUM_PORTS-1:0] fire_n;
        logic                       hs;
        logic                       vs;
        logic                       ce_10m7;
        logic                       ce_5m3;

        vector_t     vectors [$];
        int          checks;
        int          errors;
        int          cycle_count;
        int          cycle_limit;
        logic [31:0] lcg_state;

        adam_io_top uut (
                .CLK_VIDEO        (CLK_VIDEO),
                .arst_n_i         (arst_n),
                .joy0_i           (joy0),
                .joy1_i           (joy1),
                .swap_i           (swap),
                .ctrl_sel_key_n_i (sel_key_n),
                .ctrl_sel_joy_n_i (sel_joy_n),
                .ctrl_nibble_o    (nibble),
                .ctrl_fire_n_o    (fire_n),
                .hsync_n_i        (hsync_n),
                .vsync_n_i        (vsync_n),
                .hs_o             (hs),
                .vs_o             (vs),
                .ce_10m7_o        (ce_10m7),
                .ce_5m3_o         (ce_5m3)
        );

        initial begin
                CLK_VIDEO = 1'b0;
                forever #5 CLK_VIDEO = ~CLK_VIDEO;
        end

        // Watchdog on the whole run
        always @(posedge CLK_VIDEO) begin
                cycle_count = cycle_count + 1;
                if (cycle_count > cycle_limit) begin
                        $display("Run stopped: still running after %0d cycles", cycle_limit);
                        $display("Something failed");
                        $finish;
                end
        end

        //====================
        // Helpers
        //====================
        function automatic logic [31:0] lcg_next(input logic [31:0] state);
                return state * 32'd1103515245 + 32'd12345;
        endfunction

        task automatic check_nibble(input string what, input adam_io_pkg::port_nibble_u got,
                                    input adam_io_pkg::port_nibble_u exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
                end
        endtask

        task automatic check_fire(input string what, input logic [`ADAM_NUM_PORTS-1:0] got,
                                  input logic [`ADAM_NUM_PORTS-1:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
                end
        endtask

        task automatic check_bit(input string what, input logic got, input logic exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
                end
        endtask

        task automatic report_test(input string name, input int mismatches);
                if (mismatches == 0) begin
                        $display("%s: pass", name);
                end else begin
                        $display("%s: FAIL with %0d mismatches", name, mismatches);
                end
        endtask

        task automatic load_vectors();
                int          fd;
                int          rc;
                string       line;
                logic [31:0] j0, j1, sw, sk, sj, n0, n1, fr;
                vector_t     v;

                fd = $fopen("adam_io_vectors.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("Could not open adam_io_vectors.txt for reading");
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                             j0, j1, sw, sk, sj, n0, n1, fr);
                                // Comment lines yield no fields
                                if (rc == 8) begin
                                        v.joy0        = j0;
                                        v.joy1        = j1;
                                        v.swap        = sw[0];
                                        v.sel_key_n   = sk[`ADAM_NUM_PORTS-1:0];
                                        v.sel_joy_n   = sj[`ADAM_NUM_PORTS-1:0];
                                        v.exp_nibble0 = n0[`ADAM_NIBBLE_W-1:0];
                                        v.exp_nibble1 = n1[`ADAM_NIBBLE_W-1:0];
                                        v.exp_fire_n  = fr[`ADAM_NUM_PORTS-1:0];
                                        vectors.push_back(v);
                                end
                        end
                        $fclose(fd);
                        if (vectors.size() == 0) begin
                                errors++;
                                $display("No vectors found in adam_io_vectors.txt");
                        end
                end
        endtask

        //====================
        // Test sequence
        //====================
        initial begin
                int                        n;
                int                        test_errors;
                logic                      exp_hs;
                logic                      exp_vs;
                logic                      cur_h;
                logic                      cur_v;
                adam_io_pkg::port_nibble_u exp_nib;

                arst_n      = 1'b0;
                joy0        = '0;
                joy1        = '0;
                swap        = 1'b0;
                sel_key_n   = '1;
                sel_joy_n   = '1;
                hsync_n     = 1'b1;
                vsync_n     = 1'b1;
                checks      = 0;
                errors      = 0;
                cycle_count = 0;
                lcg_state   = 32'h5540;
                load_vectors();
                cycle_limit = RESET_CYCLES + CE_CYCLES + vectors.size() + SYNC_CYCLES + 200;

                repeat (RESET_CYCLES) @(posedge CLK_VIDEO);
                arst_n <= 1'b1;

                // First pulse of both enables on the first edge after release
                test_errors = errors;
                for (n = 0; n < CE_CYCLES; n++) begin
                        @(posedge CLK_VIDEO);
                        @(negedge CLK_VIDEO);
                        check_bit("ce_10m7_o", ce_10m7, (n % 4) == 0);
                        check_bit("ce_5m3_o", ce_5m3, (n % 8) == 0);
                end
                report_test("clock enables", errors - test_errors);

                for (n = 0; n < vectors.size(); n++) begin
                        test_errors = errors;
                        @(posedge CLK_VIDEO);
                        joy0      <= vectors[n].joy0;
                        joy1      <= vectors[n].joy1;
                        swap      <= vectors[n].swap;
                        sel_key_n <= vectors[n].sel_key_n;
                        sel_joy_n <= vectors[n].sel_joy_n;
                        @(negedge CLK_VIDEO);
                        exp_nib.key_code = vectors[n].exp_nibble0;
                        check_nibble("port 0 nibble", nibble[0], exp_nib);
                        exp_nib.key_code = vectors[n].exp_nibble1;
                        check_nibble("port 1 nibble", nibble[1], exp_nib);
                        check_fire("fire lines", fire_n, vectors[n].exp_fire_n);
                        report_test($sformatf("vector %0d", n + 1), errors - test_errors);
                end

                // Reference model clocks the sync levels held through each edge
                test_errors = errors;
                exp_hs = 1'b0;
                exp_vs = 1'b0;
                cur_h  = 1'b1;
                cur_v  = 1'b1;
                for (n = 0; n < SYNC_CYCLES; n++) begin
                        @(posedge CLK_VIDEO);
                        if (!exp_hs && !cur_h) begin
                                exp_vs = !cur_v;
                        end
                        exp_hs    = !cur_h;
                        lcg_state = lcg_next(lcg_state);
                        // Hsync low about a quarter of the time
                        cur_h     = lcg_state[30] | lcg_state[29];
                        cur_v     = lcg_state[27];
                        hsync_n  <= cur_h;
                        vsync_n  <= cur_v;
                        @(negedge CLK_VIDEO);
                        check_bit("hs_o", hs, exp_hs);
                        check_bit("vs_o", vs, exp_vs);
                end
                report_test("sync conditioning", errors - test_errors);

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

`default_nettype wire
